//--- int_div_unit.f
+incdir+verilog
verilog/int_div_pkg.sv
verilog/div_stage.sv
verilog/div_operand_decode.sv
verilog/div_iterate.sv
verilog/div_result_fix.sv
verilog/int_div_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_int_div_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build the integer divide unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f int_div_unit.f --top-module tb_int_div_unit -o tb_int_div_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_int_div_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

//--- testbench/int_div_patterns.txt
# flags(bit2 unsigned, bit1 rv32, bit0 remainder) dividend divisor expected
# all values hex, one operation per line
4 0000000000000064 0000000000000007 000000000000000e
5 0000000000000064 0000000000000007 0000000000000002
0 ffffffffffffff9c 0000000000000007 fffffffffffffff2
1 ffffffffffffff9c 0000000000000007 fffffffffffffffe
0 0000000000000064 fffffffffffffff9 fffffffffffffff2
1 0000000000000064 fffffffffffffff9 0000000000000002
0 ffffffffffffff9c fffffffffffffff9 000000000000000e
1 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
4 ffffffffffffffff 0000000000000010 0fffffffffffffff
5 ffffffffffffffff 0000000000000010 000000000000000f
4 123456789abcdef0 0000000100000000 0000000012345678
5 123456789abcdef0 0000000100000000 000000009abcdef0
4 fedcba9876543210 8000000000000000 0000000000000001
5 fedcba9876543210 8000000000000000 7edcba9876543210
4 8000000000000000 ffffffffffffffff 0000000000000000
0 7fffffffffffffff 0000000000000003 2aaaaaaaaaaaaaaa
1 8000000000000001 0000000000000003 ffffffffffffffff
6 deadbeefffffff00 1234567800000001 ffffffffffffff00
6 1111111180000007 aaaaaaaa00000010 0000000008000000
7 1111111180000007 aaaaaaaa00000010 0000000000000007
2 00000000fffffff9 ffffffff00000002 fffffffffffffffd
3 00000000fffffff9 ffffffff00000002 ffffffffffffffff
2 ffffffff00000064 00000000fffffff9 fffffffffffffff2
4 0000000000001234 0000000000000000 ffffffffffffffff
5 0000000000001234 0000000000000000 0000000000001234
0 fffffffffffffffb 0000000000000000 ffffffffffffffff
1 fffffffffffffffb 0000000000000000 fffffffffffffffb
2 0000000180000000 ffffffff00000000 ffffffffffffffff
3 0000000180000000 ffffffff00000000 ffffffff80000000
6 0000000000000005 1111111100000000 ffffffffffffffff
7 0000000090000000 1111111100000000 ffffffff90000000
0 8000000000000000 ffffffffffffffff 8000000000000000
1 8000000000000000 ffffffffffffffff 0000000000000000
2 0000000080000000 00000000ffffffff ffffffff80000000
3 0000000080000000 00000000ffffffff 0000000000000000

//--- testbench/tb_int_div_unit.sv
// --------------------
// Testbench for the integer divide unit
// Pattern file results, latency and busy behavior
// --------------------
`timescale 1ns/1ns
`include "int_div_config.svh"

module tb_int_div_unit import int_div_pkg::*;;

    localparam int RESULT_EDGES = `INT_DIV_LATENCY - 1;  // Accepting edge to o_valid
    localparam int WAIT_LIMIT = 20;

    logic     i_clk;
    logic     i_nrst;
    logic     i_ena;
    div_cmd_t i_cmd;
    xlen_t    i_a1;
    xlen_t    i_a2;
    xlen_t    o_res;
    logic     o_valid;
    logic     o_busy;

    div_cmd_t pat_cmd[$];
    xlen_t    pat_a1[$];
    xlen_t    pat_a2[$];
    xlen_t    pat_exp[$];
    int       errors;
    int       timeouts;
    integer   seed;

    tb_clock_gen u_clock (
        .o_clk  (i_clk),
        .o_nrst (i_nrst)
    );

    int_div_unit DUT (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_ena   (i_ena),
        .i_cmd   (i_cmd),
        .i_a1    (i_a1),
        .i_a2    (i_a2),
        .o_res   (o_res),
        .o_valid (o_valid),
        .o_busy  (o_busy)
    );

    task automatic check_res(input string name, input int idx, input xlen_t got,
                             input xlen_t expected);
        if (got !== expected) begin
            $display("ERR %s pattern %0d: got 0x%h exp 0x%h", name, idx, got, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERR %s at %0t: got 0x%h exp 0x%h", name, $time, got, expected);
            errors++;
        end
    endtask

    task automatic load_patterns();
        int         fd;
        int         cnt;
        string      line;
        logic [3:0] flags;
        xlen_t      a1;
        xlen_t      a2;
        xlen_t      expected;

        fd = $fopen("testbench/int_div_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                // Comment and blank lines fall through
                if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h", flags, a1, a2, expected);
                    if (cnt == 4) begin
                        pat_cmd.push_back(div_cmd_t'(flags[2:0]));
                        pat_a1.push_back(a1);
                        pat_a2.push_back(a2);
                        pat_exp.push_back(expected);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_op(input int idx);
        i_ena = 1'b1;
        i_cmd = pat_cmd[idx];
        i_a1 = pat_a1[idx];
        i_a2 = pat_a2[idx];
    endtask

    // Starts just after the accepting edge, ends 1 ns into the o_valid cycle
    task automatic await_result(input int idx, input int ena_hold);
        int   n;
        logic seen;

        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(posedge i_clk);
            #1;
            n++;
            if (o_valid) begin
                seen = 1'b1;
            end else begin
                check_flag("o_busy", o_busy, 1'b1);
                #1;
                if (n == ena_hold) begin
                    i_ena = 1'b0;                   // End of the strobe given while busy
                end
            end
        end
        if (!seen) begin
            $display("Timeout: no o_valid within %0d cycles for pattern %0d", WAIT_LIMIT, idx);
            timeouts++;
        end else begin
            if (n != RESULT_EDGES) begin
                $display("ERR o_valid latency pattern %0d: got 0x%0h exp 0x%0h",
                         idx, n, RESULT_EDGES);
                errors++;
            end
            check_res("o_res", idx, o_res, pat_exp[idx]);
            check_flag("o_busy", o_busy, 1'b0);
        end
    endtask

    task automatic run_single(input int idx);
        @(posedge i_clk);
        #2;
        check_flag("o_busy", o_busy, 1'b0);
        drive_op(idx);
        @(posedge i_clk);                           // Accepting edge
        #2;
        i_ena = 1'b0;
        await_result(idx, 0);
        @(posedge i_clk);
        #1;
        check_flag("o_valid", o_valid, 1'b0);       // One-cycle pulse
    endtask

    // A second operation offered during busy must vanish
    task automatic run_busy_drop(input int idx, input int other);
        int k;

        @(posedge i_clk);
        #2;
        drive_op(idx);
        @(posedge i_clk);
        #2;
        drive_op(other);
        await_result(idx, 4);
        for (k = 0; k < 12; k++) begin
            @(posedge i_clk);
            #1;
            check_flag("o_valid", o_valid, 1'b0);
        end
        check_flag("o_busy", o_busy, 1'b0);
    endtask

    task automatic run_chain();
        int k;

        @(posedge i_clk);
        #2;
        drive_op(0);
        for (k = 0; k < pat_exp.size(); k++) begin
            @(posedge i_clk);                       // Accepting edge
            #2;
            i_ena = 1'b0;
            await_result(k, 0);
            if (k + 1 < pat_exp.size()) begin
                #1;
                drive_op(k + 1);                    // Strobe in the o_valid cycle
            end
        end
        @(posedge i_clk);
        #1;
        check_flag("o_valid", o_valid, 1'b0);
    endtask

    initial begin : main
        int k;
        int n;
        int gap;

        errors = 0;
        timeouts = 0;
        seed = 32'h836c;
        i_ena = 1'b0;
        i_cmd = '0;
        i_a1 = '0;
        i_a2 = '0;
        load_patterns();

        n = 0;
        while (!i_nrst && n < WAIT_LIMIT) begin
            @(posedge i_clk);
            n++;
        end
        if (!i_nrst) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        @(posedge i_clk);
        #1;
        check_flag("o_valid", o_valid, 1'b0);
        check_flag("o_busy", o_busy, 1'b0);

        if (pat_exp.size() < 2) begin
            $display("Pattern file holds too few operations");
            errors++;
        end else begin
            for (k = 0; k < pat_exp.size(); k++) begin
                run_single(k);
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(posedge i_clk);
            end
            run_busy_drop(0, 1);
            run_chain();
        end

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
// --------------------
// Testbench clock and reset source
// --------------------
`timescale 1ns/1ns

module tb_clock_gen (
    output logic o_clk,
    output logic o_nrst
);

    localparam int HALF_PERIOD = 10;                // 20 ns clock

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset low over the first 3 rising edges
    initial begin
        o_nrst = 1'b0;
        repeat (3) @(posedge o_clk);
        #2 o_nrst = 1'b1;
    end

endmodule

//--- verilog/int_div_unit.sv
// --------------------
// Integer divide unit, RV64 DIV/REM and word forms
// --------------------
`timescale 1ns/1ns
`include "int_div_config.svh"

module int_div_unit import int_div_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_ena,                         // One-cycle operation strobe
    input  div_cmd_t i_cmd,
    input  xlen_t    i_a1,
    input  xlen_t    i_a2,
    output xlen_t    o_res,
    output logic     o_valid,                       // One-cycle result strobe
    output logic     o_busy
);

    div_req_t   req;
    logic       req_valid;
    div_raw_t   raw;
    logic       raw_valid;
    div_flags_t flags;

    div_operand_decode u_decode (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_ena       (i_ena),
        .i_cmd       (i_cmd),
        .i_a1        (i_a1),
        .i_a2        (i_a2),
        .i_done      (o_valid),
        .o_req       (req),
        .o_req_valid (req_valid),
        .o_busy      (o_busy)
    );

    div_iterate u_iterate (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (req),
        .i_req_valid (req_valid),
        .o_raw       (raw),
        .o_raw_valid (raw_valid)
    );

    // Flags stay valid in the decode register for the whole operation
    assign flags = '{cmd:         req.cmd,
                     invert:      req.invert,
                     div_on_zero: req.div_on_zero,
                     overflow:    req.overflow};

    div_result_fix u_result (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_flags     (flags),
        .i_raw       (raw),
        .i_raw_valid (raw_valid),
        .o_res       (o_res),
        .o_valid     (o_valid)
    );

endmodule

//--- verilog/div_result_fix.sv
// --------------------
// Divide result fix-up
// Sign, special cases and word sign-extension, registered out
// --------------------
`timescale 1ns/1ns
`include "int_div_config.svh"

module div_result_fix import int_div_pkg::*; (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  div_flags_t i_flags,
    input  div_raw_t   i_raw,
    input  logic       i_raw_valid,
    output xlen_t      o_res,
    output logic       o_valid
);

    localparam int XLEN = `INT_DIV_XLEN;
    localparam int HALF = XLEN / 2;

    // Most negative value, full width and sign-extended word
    localparam xlen_t MIN_XLEN = {1'b1, {(XLEN-1){1'b0}}};
    localparam xlen_t MIN_WORD = {{(HALF+1){1'b1}}, {(HALF-1){1'b0}}};

    xlen_t quot;
    xlen_t rem;
    xlen_t res_d;

    always_comb begin
        quot = i_flags.invert ? (~i_raw.quotient + 1'b1) : i_raw.quotient;
        rem = i_flags.invert ? (~i_raw.remainder + 1'b1) : i_raw.remainder;

        if (i_flags.cmd.rv32) begin                 // W forms sign-extend bit 31
            quot = {{HALF{quot[HALF-1]}}, quot[HALF-1:0]};
            rem = {{HALF{rem[HALF-1]}}, rem[HALF-1:0]};
        end

        if (i_flags.cmd.residual) begin
            res_d = i_flags.overflow ? '0 : rem;    // Divide by zero keeps dividend
        end else if (i_flags.div_on_zero) begin
            res_d = '1;
        end else if (i_flags.overflow) begin
            res_d = i_flags.cmd.rv32 ? MIN_WORD : MIN_XLEN;
        end else begin
            res_d = quot;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_res <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_raw_valid;
            if (i_raw_valid) begin
                o_res <= res_d;                     // Held until next result
            end
        end
    end

    a_single_valid: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_valid |=> !o_valid)
        else $error("o_valid high for more than one cycle");

endmodule

//--- verilog/div_iterate.sv
// --------------------
// Iterative divider core
// Two chained radix-16 stages, 8 quotient bits per clock
// --------------------
`timescale 1ns/1ns
`include "int_div_config.svh"

module div_iterate import int_div_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  div_req_t i_req,
    input  logic     i_req_valid,                   // Start strobe
    output div_raw_t o_raw,
    output logic     o_raw_valid
);

    localparam int XLEN = `INT_DIV_XLEN;
    localparam int SB = `INT_DIV_STEP_BITS;
    localparam int STEPS = XLEN / SB;
    localparam int CNT_W = $clog2(STEPS);
    localparam int DIVR_W = 2 * XLEN - SB;          // Divisor starts at bit XLEN-SB

    iter_state_t       state_q;
    logic [CNT_W-1:0]  cnt_q;
    logic              start;
    logic              step;
    xlen_t             rem_q;
    xlen_t             rem_src;
    xlen_t             quot_q;
    logic [DIVR_W-1:0] divr_q;
    logic [DIVR_W-1:0] divr_src;
    logic [XLEN+3:0]   win_hi;
    logic [XLEN+3:0]   win_lo;
    xlen_t             resid_hi;
    xlen_t             resid_lo;
    logic [3:0]        bits_hi;
    logic [3:0]        bits_lo;

    assign start = (state_q == ITER_IDLE) && i_req_valid;
    assign step = start || (state_q == ITER_RUN);

    // First step works straight from the request
    assign rem_src = start ? i_req.dividend : rem_q;
    assign divr_src = start ? {i_req.divisor, {(XLEN-SB){1'b0}}} : divr_q;

    // Any bit above the window means the shifted divisor exceeds the remainder
    assign win_hi = (|divr_src[DIVR_W-1:XLEN]) ? '1 : {divr_src[XLEN-1:0], 4'b0};
    assign win_lo = (|divr_src[DIVR_W-1:XLEN+4]) ? '1 : divr_src[XLEN+3:0];

    div_stage stage_hi (
        .i_dividend (rem_src),
        .i_divisor  (win_hi),
        .o_resid    (resid_hi),
        .o_bits     (bits_hi)
    );

    div_stage stage_lo (
        .i_dividend (resid_hi),
        .i_divisor  (win_lo),
        .o_resid    (resid_lo),
        .o_bits     (bits_lo)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= ITER_IDLE;
            cnt_q <= '0;
            o_raw_valid <= 1'b0;
        end else begin
            o_raw_valid <= 1'b0;
            if (start) begin
                state_q <= ITER_RUN;
                cnt_q <= CNT_W'(1);
            end else if (state_q == ITER_RUN) begin
                if (cnt_q == CNT_W'(STEPS-1)) begin   // Last step
                    state_q <= ITER_IDLE;
                    cnt_q <= '0;
                    o_raw_valid <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (step) begin
            rem_q <= resid_lo;
            divr_q <= divr_src >> SB;
            quot_q <= {quot_q[XLEN-SB-1:0], bits_hi, bits_lo};
        end
    end

    assign o_raw = '{quotient: quot_q, remainder: rem_q};

    a_no_start_while_running: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state_q == ITER_RUN) |-> !i_req_valid)
        else $error("divide start while iterator running");

endmodule

//--- verilog/div_operand_decode.sv
// --------------------
// Divide operand decode
// Magnitudes, sign and special-case flags, busy tracking
// --------------------
`timescale 1ns/1ns
`include "int_div_config.svh"

module div_operand_decode import int_div_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_ena,                         // Operation strobe
    input  div_cmd_t i_cmd,
    input  xlen_t    i_a1,                          // Dividend
    input  xlen_t    i_a2,                          // Divisor
    input  logic     i_done,                        // Result strobe from result stage
    output div_req_t o_req,
    output logic     o_req_valid,
    output logic     o_busy
);

    localparam int XLEN = `INT_DIV_XLEN;
    localparam int HALF = XLEN / 2;

    logic            busy_q;
    logic            accept;
    logic            a1_neg;
    logic            a2_neg;
    logic [HALF-1:0] a1_lo_mag;
    logic [HALF-1:0] a2_lo_mag;
    xlen_t           a1_mag;
    xlen_t           a2_mag;
    logic            a2_zero;
    logic            a1_min;
    logic            a2_ones;
    div_req_t        req_d;

    // Busy drops in the result cycle so a new strobe there is taken
    assign o_busy = busy_q & ~i_done;
    assign accept = i_ena & ~o_busy;

    always_comb begin
        if (i_cmd.rv32) begin
            a1_neg = ~i_cmd.is_unsigned & i_a1[HALF-1];
            a2_neg = ~i_cmd.is_unsigned & i_a2[HALF-1];
            a1_lo_mag = a1_neg ? (~i_a1[HALF-1:0] + 1'b1) : i_a1[HALF-1:0];
            a2_lo_mag = a2_neg ? (~i_a2[HALF-1:0] + 1'b1) : i_a2[HALF-1:0];
            a1_mag = {{HALF{1'b0}}, a1_lo_mag};
            a2_mag = {{HALF{1'b0}}, a2_lo_mag};
            a2_zero = ~|i_a2[HALF-1:0];
            a1_min = (a1_lo_mag == {1'b1, {(HALF-1){1'b0}}});
            a2_ones = &i_a2[HALF-1:0];
        end else begin
            a1_neg = ~i_cmd.is_unsigned & i_a1[XLEN-1];
            a2_neg = ~i_cmd.is_unsigned & i_a2[XLEN-1];
            a1_lo_mag = '0;
            a2_lo_mag = '0;
            a1_mag = a1_neg ? (~i_a1 + 1'b1) : i_a1;
            a2_mag = a2_neg ? (~i_a2 + 1'b1) : i_a2;
            a2_zero = ~|i_a2;
            a1_min = (a1_mag == {1'b1, {(XLEN-1){1'b0}}});
            a2_ones = &i_a2;
        end

        req_d.cmd = i_cmd;
        req_d.dividend = a1_mag;
        req_d.divisor = a2_mag;
        // Remainder takes the dividend sign, quotient the sign product
        req_d.invert = i_cmd.residual ? a1_neg : (a1_neg ^ a2_neg);
        req_d.div_on_zero = a2_zero;
        req_d.overflow = ~i_cmd.is_unsigned & a1_min & a2_ones;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy_q <= 1'b0;
            o_req_valid <= 1'b0;
        end else begin
            o_req_valid <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (i_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Held until the next accept so the result stage can read the flags here
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_req <= req_d;
        end
    end

    // A request always comes with busy raised, never with a result strobe
    a_busy_with_request: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_req_valid |-> o_busy)
        else $error("divide request issued without busy raised");

    a_fixed_latency: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_req_valid |-> ##(`INT_DIV_LATENCY-1) i_done)
        else $error("divide result did not arrive at the fixed latency");

endmodule

//--- verilog/div_stage.sv
// --------------------
// Radix-16 divide stage
// Four restoring compare-subtract steps, 4 quotient bits out
// --------------------
`timescale 1ns/1ns
`include "int_div_config.svh"

module div_stage import int_div_pkg::*; (
    input  xlen_t                   i_dividend,     // Partial remainder in
    input  logic [`INT_DIV_XLEN+3:0] i_divisor,     // Window, saturated by caller
    output xlen_t                   o_resid,        // Partial remainder out
    output logic [3:0]              o_bits          // Quotient bits, MSB first
);

    localparam int XLEN = `INT_DIV_XLEN;
    // Room for the window shifted by up to 3
    localparam int CMP_W = XLEN + 7;

    always_comb begin : steps
        logic [CMP_W-1:0] rem;
        logic [CMP_W-1:0] sub;

        rem = CMP_W'(i_dividend);
        o_bits = '0;

        // Highest shift first, as in long division
        for (int j = 3; j >= 0; j--) begin
            sub = CMP_W'(i_divisor) << j;
            if (rem >= sub) begin
                rem = rem - sub;
                o_bits[j] = 1'b1;
            end
        end

        // Upper bits are zero once a subtraction has been restored
        o_resid = rem[XLEN-1:0];
    end

endmodule

//--- verilog/int_div_pkg.sv
// --------------------
// Integer divide unit types
// --------------------
`include "int_div_config.svh"

package int_div_pkg;

    typedef logic [`INT_DIV_XLEN-1:0] xlen_t;     // Operand and result word

    // Operation as seen by the core
    typedef struct packed {
        logic is_unsigned;                          // DIVU/REMU forms
        logic rv32;                                 // Word forms, low 32 bits only
        logic residual;                             // Remainder instead of quotient
    } div_cmd_t;

    // Decoded operation handed to the iterator
    typedef struct packed {
        div_cmd_t cmd;
        xlen_t    dividend;                         // Magnitude
        xlen_t    divisor;                          // Magnitude
        logic     invert;                           // Negate the selected result
        logic     div_on_zero;
        logic     overflow;                         // Most negative by -1
    } div_req_t;

    // Unsigned result of the iterator
    typedef struct packed {
        xlen_t quotient;
        xlen_t remainder;
    } div_raw_t;

    // Decode flags needed by the result stage
    typedef struct packed {
        div_cmd_t cmd;
        logic     invert;
        logic     div_on_zero;
        logic     overflow;
    } div_flags_t;

    typedef enum logic {
        ITER_IDLE,
        ITER_RUN
    } iter_state_t;

endpackage

//--- verilog/int_div_config.svh
// --------------------
// Integer divide unit configuration
// --------------------
`ifndef INT_DIV_CONFIG_SVH
`define INT_DIV_CONFIG_SVH

// Operand and result width
`define INT_DIV_XLEN 64

// Quotient bits produced per clock, two radix-16 stages
`define INT_DIV_STEP_BITS 8

// Edges from the accepting edge to o_valid, both counted
`define INT_DIV_LATENCY 10

`endif
